// ==== list.f ====
source/stap_pkg.sv
source/stap_fsm.sv
source/stap_ir.sv
source/stap_dr.sv
source/stap_tdo.sv
source/stap.sv
dv/stap_clk_gen.sv
dv/stap_tb.sv

// ==== Makefile ====
# Verilator build and run for the stap testbench

VERILATOR ?= verilator
TOP       ?= stap_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

# Sources come from the file list, so the binary tracks every listed file
SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "^All checks passed$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/stap_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module stap_tb;
    import stap_pkg::*;

    localparam logic [31:0] SEED = 32'h93b9_1322;
    localparam int TEST_LOOPS  = 6;
    localparam int CYCLE_LIMIT = TEST_LOOPS * 2000 + 500;
    localparam int RAND_ITERS  = 80;

    // Register picked by the model
    localparam int SEL_BYPASS = 0;
    localparam int SEL_IDCODE = 1;
    localparam int SEL_TDR    = 2;
    localparam int SEL_SEC    = 3;

    logic                   ftap_tck;
    logic                   rst_n;
    logic                   ftap_tms;
    logic                   ftap_tdi;
    idcode_t                ftap_slvidcode;
    logic [2*TDR_WIDTH-1:0] tdr_data_in;
    policy_t                fdfx_secure_policy;
    logic                   fdfx_policy_update;
    logic                   ftap_tdo;
    logic                   ftap_tdoen;
    logic [2*TDR_WIDTH-1:0] tdr_data_out;

    // Reference model state
    tap_state_t state_m;
    ir_t        ir_m;
    policy_t    policy_m;
    logic       sec_open_m;
    tdr_t       tdr_m;
    tdr_t       sec_tdr_m;

    int errors;
    int checks;
    int cycles;

    stap_clk_gen u_clk_gen (
        .ftap_tck (ftap_tck),
        .rst_n    (rst_n)
    );

    stap u_stap (
        .ftap_tck           (ftap_tck),
        .rst_n              (rst_n),
        .ftap_tms           (ftap_tms),
        .ftap_tdi           (ftap_tdi),
        .ftap_slvidcode     (ftap_slvidcode),
        .tdr_data_in        (tdr_data_in),
        .fdfx_secure_policy (fdfx_secure_policy),
        .fdfx_policy_update (fdfx_policy_update),
        .ftap_tdo           (ftap_tdo),
        .ftap_tdoen         (ftap_tdoen),
        .tdr_data_out       (tdr_data_out)
    );

    // ------------------------------------------------------------------
    // Model of the 1149.1 controller and the instruction decode
    // ------------------------------------------------------------------

    function automatic tap_state_t next_state(tap_state_t s, logic tms);
        case (s)
            TAP_TLR:      return tms ? TAP_TLR      : TAP_RTI;
            TAP_RTI:      return tms ? TAP_SEL_DR   : TAP_RTI;
            TAP_SEL_DR:   return tms ? TAP_SEL_IR   : TAP_CAP_DR;
            TAP_CAP_DR:   return tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR: return tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR: return tms ? TAP_UPD_DR   : TAP_PAUSE_DR;
            TAP_PAUSE_DR: return tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR: return tms ? TAP_UPD_DR   : TAP_SHIFT_DR;
            TAP_UPD_DR:   return tms ? TAP_SEL_DR   : TAP_RTI;
            TAP_SEL_IR:   return tms ? TAP_TLR      : TAP_CAP_IR;
            TAP_CAP_IR:   return tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR: return tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR: return tms ? TAP_UPD_IR   : TAP_PAUSE_IR;
            TAP_PAUSE_IR: return tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR: return tms ? TAP_UPD_IR   : TAP_SHIFT_IR;
            TAP_UPD_IR:   return tms ? TAP_SEL_DR   : TAP_RTI;
            default:      return TAP_TLR;
        endcase
    endfunction

    // Unlisted codes and a locked secure TDR fall back to bypass
    function automatic int select_of(ir_t ir, logic sec_open);
        if (ir == IR_IDCODE) return SEL_IDCODE;
        if (ir == IR_TDR) return SEL_TDR;
        if (ir == IR_SEC_TDR && sec_open) return SEL_SEC;
        return SEL_BYPASS;
    endfunction

    // Weighted toward the listed codes
    function automatic ir_t pick_code();
        logic [31:0] rnd;
        rnd = $urandom;
        case (rnd[2:0])
            3'd0:       return IR_IDCODE;
            3'd1, 3'd2: return IR_TDR;
            3'd3, 3'd4: return IR_SEC_TDR;
            3'd5:       return IR_BYPASS;
            default:    return rnd[7:4];
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------

    task automatic check_ir(input string name, input ir_t exp, input ir_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_idcode(input string name, input idcode_t exp, input idcode_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_tdr(input string name, input tdr_t exp, input tdr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    // ------------------------------------------------------------------
    // JTAG driver
    // ------------------------------------------------------------------

    // One tck: TMS and TDI on the falling edge, TDO taken at the rising edge
    task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
        logic shifting;
        @(negedge ftap_tck);
        ftap_tms = tms;
        ftap_tdi = tdi;
        shifting = (state_m == TAP_SHIFT_IR) || (state_m == TAP_SHIFT_DR);
        @(posedge ftap_tck);
        tdo = ftap_tdo;
        // Enable tracks the shift states and nothing else
        check_bit("ftap_tdoen", shifting, ftap_tdoen);
        if (state_m == TAP_TLR) begin
            ir_m       = IR_IDCODE;
            sec_open_m = 1'b0;
        end
        state_m = next_state(state_m, tms);
    endtask

    // Five TMS-high clocks, then park in Run-Test/Idle
    task automatic tap_reset();
        logic b;
        repeat (5) tck_cycle(1'b1, 1'b0, b);
        tck_cycle(1'b0, 1'b0, b);
    endtask

    // Last bit carries TMS high into Exit1
    task automatic shift_bits(input int n, input logic [31:0] tdi_bits,
                              output logic [31:0] tdo_bits);
        logic b;
        tdo_bits = '0;
        for (int i = 0; i < n; i++) begin
            tck_cycle(i == n - 1, tdi_bits[i], b);
            tdo_bits[i] = b;
        end
    endtask

    // Exit1 to Update, then back to idle
    task automatic exit_through_update();
        logic b;
        tck_cycle(1'b1, 1'b0, b);
        tck_cycle(1'b0, 1'b0, b);
    endtask

    // Outputs settle one half cycle after leaving Update-DR
    task automatic check_parallel();
        @(negedge ftap_tck);
        check_tdr("tdr_data_out[15:0]", tdr_m, tdr_data_out[TDR_WIDTH-1:0]);
        check_tdr("tdr_data_out[31:16]", sec_tdr_m, tdr_data_out[2*TDR_WIDTH-1:TDR_WIDTH]);
    endtask

    // Policy loads on the one rising edge with the update pulse high
    task automatic pulse_policy(input policy_t p);
        @(negedge ftap_tck);
        fdfx_secure_policy = p;
        fdfx_policy_update = 1'b1;
        @(negedge ftap_tck);
        fdfx_policy_update = 1'b0;
        policy_m = p;
    endtask

    task automatic run_ir_scan(input ir_t code);
        logic [31:0] tdi_bits;
        logic [31:0] tdo_bits;
        logic        b;
        // Idle to Select-DR, Select-IR, Capture-IR and into Shift-IR
        tck_cycle(1'b1, 1'b0, b);
        tck_cycle(1'b1, 1'b0, b);
        tck_cycle(1'b0, 1'b0, b);
        tck_cycle(1'b0, 1'b0, b);
        tdi_bits = {{(32-IR_WIDTH){1'b0}}, code};
        shift_bits(IR_WIDTH, tdi_bits, tdo_bits);
        check_ir("ftap_tdo ir capture", IR_CAPTURE, tdo_bits[IR_WIDTH-1:0]);
        exit_through_update();
        ir_m       = code;
        sec_open_m = (policy_m == POLICY_UNLOCK);
    endtask

    // Full DR scan of the register the model selects
    task automatic run_dr_scan();
        logic [31:0] tdi_bits;
        logic [31:0] tdo_bits;
        logic [31:0] exp_bits;
        logic        b;
        int          sel;
        int          n;
        sel = select_of(ir_m, sec_open_m);
        // Fresh parallel inputs while idle
        @(negedge ftap_tck);
        ftap_slvidcode = $urandom;
        tdr_data_in    = $urandom;
        tdi_bits       = $urandom;
        case (sel)
            SEL_IDCODE:       n = 32;
            SEL_TDR, SEL_SEC: n = TDR_WIDTH;
            default:          n = $urandom_range(32, 2);
        endcase
        tck_cycle(1'b1, 1'b0, b);
        tck_cycle(1'b0, 1'b0, b);
        tck_cycle(1'b0, 1'b0, b);
        shift_bits(n, tdi_bits, tdo_bits);
        exit_through_update();
        case (sel)
            SEL_IDCODE: begin
                check_idcode("ftap_tdo idcode", ftap_slvidcode, tdo_bits);
            end
            SEL_TDR: begin
                check_tdr("ftap_tdo tdr", tdr_data_in[TDR_WIDTH-1:0], tdo_bits[TDR_WIDTH-1:0]);
                tdr_m = tdi_bits[TDR_WIDTH-1:0];
            end
            SEL_SEC: begin
                check_tdr("ftap_tdo sec_tdr", tdr_data_in[2*TDR_WIDTH-1:TDR_WIDTH],
                          tdo_bits[TDR_WIDTH-1:0]);
                sec_tdr_m = tdi_bits[TDR_WIDTH-1:0];
            end
            default: begin
                // One-bit delay, bypass cell captured 0
                exp_bits = {tdi_bits[30:0], 1'b0};
                for (int i = 0; i < n; i++) begin
                    check_bit("ftap_tdo bypass", exp_bits[i], tdo_bits[i]);
                end
            end
        endcase
        check_parallel();
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------

    initial begin : main
        logic [31:0] rnd;
        ir_t         code;
        int          choice;
        void'($urandom(SEED));
        ftap_tms           = 1'b1;
        ftap_tdi           = 1'b0;
        ftap_slvidcode     = '0;
        tdr_data_in        = '0;
        fdfx_secure_policy = '0;
        fdfx_policy_update = 1'b0;
        state_m    = TAP_TLR;
        ir_m       = IR_IDCODE;
        policy_m   = '0;
        sec_open_m = 1'b0;
        tdr_m      = '0;
        sec_tdr_m  = '0;
        errors     = 0;
        checks     = 0;
        wait (rst_n === 1'b1);

        // Reset values, then IDCODE with no IR load
        check_parallel();
        check_bit("ftap_tdoen", 1'b0, ftap_tdoen);
        tck_cycle(1'b0, 1'b0, rnd[0]);
        run_dr_scan();

        // IR capture pattern
        run_ir_scan(IR_IDCODE);
        run_dr_scan();

        // Open TDR
        repeat (6) begin
            run_ir_scan(IR_TDR);
            run_dr_scan();
            run_dr_scan();
        end

        // Bypass and unlisted codes
        repeat (8) begin
            code = pick_code();
            if (code == IR_IDCODE || code == IR_TDR || code == IR_SEC_TDR) begin
                code = IR_BYPASS;
            end
            run_ir_scan(code);
            run_dr_scan();
        end

        // Secure TDR locked, then unlocked from the next Update-IR on
        run_ir_scan(IR_SEC_TDR);
        run_dr_scan();
        pulse_policy(POLICY_UNLOCK);
        run_dr_scan();
        run_ir_scan(IR_SEC_TDR);
        repeat (4) run_dr_scan();

        // Random mix with TMS resets and policy changes
        repeat (RAND_ITERS) begin
            choice = $urandom_range(9, 0);
            rnd    = $urandom;
            if (choice == 0) begin
                tap_reset();
            end else if (choice == 1) begin
                pulse_policy(rnd[0] ? POLICY_UNLOCK : policy_t'(rnd[7:4]));
            end else if (choice <= 4) begin
                run_ir_scan(pick_code());
            end else begin
                run_dr_scan();
            end
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Stops a run that never reaches the end of the sequence
    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge ftap_tck);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d tck cycles", CYCLE_LIMIT);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/stap_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module stap_clk_gen (
    output logic ftap_tck,
    output logic rst_n
);
    // 100 ns tck period
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 8;

    initial begin
        ftap_tck = 1'b0;
        forever #HALF_PERIOD ftap_tck = ~ftap_tck;
    end

    // Reset released on a falling edge, clear of the rising edge the TAP uses
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge ftap_tck);
        @(negedge ftap_tck);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== source/stap.sv ====
`timescale 1ns/1ps
`default_nettype none

module stap (
    input  logic                                 ftap_tck,
    input  logic                                 rst_n,
    input  logic                                 ftap_tms,
    input  logic                                 ftap_tdi,
    input  stap_pkg::idcode_t                    ftap_slvidcode,
    input  logic [2*stap_pkg::TDR_WIDTH-1:0]     tdr_data_in,
    input  stap_pkg::policy_t                    fdfx_secure_policy,
    input  logic                                 fdfx_policy_update,
    output logic                                 ftap_tdo,
    output logic                                 ftap_tdoen,
    output logic [2*stap_pkg::TDR_WIDTH-1:0]     tdr_data_out
);
    import stap_pkg::*;

    // Controller strobes
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic tlr;

    // Selects and serial outputs
    logic sel_idcode;
    logic sel_tdr;
    logic sel_sec_tdr;
    logic ir_so;
    logic idcode_so;
    logic tdr_so;
    logic sec_tdr_so;

    // ------------------------------------------------------------------
    // Controller and instruction register
    // ------------------------------------------------------------------

    stap_fsm u_fsm (
        .ftap_tck   (ftap_tck),
        .rst_n      (rst_n),
        .ftap_tms   (ftap_tms),
        .capture_ir (capture_ir),
        .shift_ir   (shift_ir),
        .update_ir  (update_ir),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .tlr        (tlr)
    );

    stap_ir u_ir (
        .ftap_tck           (ftap_tck),
        .rst_n              (rst_n),
        .ftap_tdi           (ftap_tdi),
        .capture_ir         (capture_ir),
        .shift_ir           (shift_ir),
        .update_ir          (update_ir),
        .tlr                (tlr),
        .fdfx_secure_policy (fdfx_secure_policy),
        .fdfx_policy_update (fdfx_policy_update),
        .ir_so              (ir_so),
        .sel_idcode         (sel_idcode),
        .sel_tdr            (sel_tdr),
        .sel_sec_tdr        (sel_sec_tdr)
    );

    // ------------------------------------------------------------------
    // Data registers
    // ------------------------------------------------------------------

    // IDCODE has no parallel output
    stap_dr #(.data_t(idcode_t), .HAS_UPDATE(1'b0)) u_idcode (
        .ftap_tck   (ftap_tck),
        .rst_n      (rst_n),
        .ftap_tdi   (ftap_tdi),
        .sel        (sel_idcode),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .par_in     (ftap_slvidcode),
        .par_out    (),
        .so         (idcode_so)
    );

    // Open TDR on the low half of the parallel bus
    stap_dr #(.data_t(tdr_t), .HAS_UPDATE(1'b1)) u_tdr (
        .ftap_tck   (ftap_tck),
        .rst_n      (rst_n),
        .ftap_tdi   (ftap_tdi),
        .sel        (sel_tdr),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .par_in     (tdr_data_in[TDR_WIDTH-1:0]),
        .par_out    (tdr_data_out[TDR_WIDTH-1:0]),
        .so         (tdr_so)
    );

    // Secure TDR on the high half
    stap_dr #(.data_t(tdr_t), .HAS_UPDATE(1'b1)) u_sec_tdr (
        .ftap_tck   (ftap_tck),
        .rst_n      (rst_n),
        .ftap_tdi   (ftap_tdi),
        .sel        (sel_sec_tdr),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .par_in     (tdr_data_in[2*TDR_WIDTH-1:TDR_WIDTH]),
        .par_out    (tdr_data_out[2*TDR_WIDTH-1:TDR_WIDTH]),
        .so         (sec_tdr_so)
    );

    // ------------------------------------------------------------------
    // TDO stage with bypass
    // ------------------------------------------------------------------

    stap_tdo u_tdo (
        .ftap_tck    (ftap_tck),
        .rst_n       (rst_n),
        .ftap_tdi    (ftap_tdi),
        .shift_ir    (shift_ir),
        .shift_dr    (shift_dr),
        .capture_dr  (capture_dr),
        .ir_so       (ir_so),
        .idcode_so   (idcode_so),
        .tdr_so      (tdr_so),
        .sec_tdr_so  (sec_tdr_so),
        .sel_idcode  (sel_idcode),
        .sel_tdr     (sel_tdr),
        .sel_sec_tdr (sel_sec_tdr),
        .ftap_tdo    (ftap_tdo),
        .ftap_tdoen  (ftap_tdoen)
    );

endmodule

`default_nettype wire

// ==== source/stap_tdo.sv ====
`timescale 1ns/1ps
`default_nettype none

module stap_tdo (
    input  logic ftap_tck,
    input  logic rst_n,
    input  logic ftap_tdi,
    input  logic shift_ir,
    input  logic shift_dr,
    input  logic capture_dr,
    input  logic ir_so,
    input  logic idcode_so,
    input  logic tdr_so,
    input  logic sec_tdr_so,
    input  logic sel_idcode,
    input  logic sel_tdr,
    input  logic sel_sec_tdr,
    output logic ftap_tdo,
    output logic ftap_tdoen
);
    logic bypass_q;
    logic dr_bit;
    logic tdo_bit;
    logic shift_en;

    // Bypass cell, zero at capture
    always_ff @(posedge ftap_tck or negedge rst_n) begin
        if (!rst_n) begin
            bypass_q <= 1'b0;
        end else if (capture_dr) begin
            bypass_q <= 1'b0;
        end else if (shift_dr) begin
            bypass_q <= ftap_tdi;
        end
    end

    // ------------------------------------------------------------------
    // Serial mux
    // ------------------------------------------------------------------

    // No select high means bypass
    assign dr_bit   = sel_idcode  ? idcode_so  :
                      sel_tdr     ? tdr_so     :
                      sel_sec_tdr ? sec_tdr_so : bypass_q;
    assign tdo_bit  = shift_ir ? ir_so : dr_bit;
    assign shift_en = shift_ir | shift_dr;

    // Retimed on falling tck so the bit is stable at the next rising edge
    always_ff @(negedge ftap_tck or negedge rst_n) begin
        if (!rst_n) begin
            ftap_tdo   <= 1'b0;
            ftap_tdoen <= 1'b0;
        end else begin
            ftap_tdo   <= shift_en ? tdo_bit : 1'b0;
            ftap_tdoen <= shift_en;
        end
    end

    // Idle pin is parked low
    a_tdo_parked : assert property (@(posedge ftap_tck) disable iff (!rst_n)
        !ftap_tdoen |-> !ftap_tdo);

endmodule

`default_nettype wire

// ==== source/stap_dr.sv ====
`timescale 1ns/1ps
`default_nettype none

module stap_dr #(
    parameter type data_t     = stap_pkg::tdr_t,
    parameter bit  HAS_UPDATE = 1'b1
) (
    input  logic  ftap_tck,
    input  logic  rst_n,
    input  logic  ftap_tdi,
    input  logic  sel,
    input  logic  capture_dr,
    input  logic  shift_dr,
    input  logic  update_dr,
    input  data_t par_in,
    output data_t par_out,
    output logic  so
);
    localparam int W = $bits(data_t);

    // Flat view of the payload keeps the shift generic
    logic [W-1:0] dr_sr;

    // ------------------------------------------------------------------
    // Capture and shift stage
    // ------------------------------------------------------------------

    // Only the selected register moves
    always_ff @(posedge ftap_tck) begin
        if (sel && capture_dr) begin
            dr_sr <= par_in;
        end else if (sel && shift_dr) begin
            dr_sr <= {ftap_tdi, dr_sr[W-1:1]};
        end
    end

    // LSB leaves first
    assign so = dr_sr[0];

    // ------------------------------------------------------------------
    // Update shadow
    // ------------------------------------------------------------------

    generate
        if (HAS_UPDATE) begin : g_shadow
            logic [W-1:0] shadow_q;

            // Parallel outputs hold steady while the chain shifts
            always_ff @(posedge ftap_tck or negedge rst_n) begin
                if (!rst_n) begin
                    shadow_q <= '0;
                end else if (sel && update_dr) begin
                    shadow_q <= dr_sr;
                end
            end

            assign par_out = data_t'(shadow_q);
        end else begin : g_no_shadow
            // Read-only register such as IDCODE
            assign par_out = '0;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== source/stap_ir.sv ====
`timescale 1ns/1ps
`default_nettype none

module stap_ir (
    input  logic              ftap_tck,
    input  logic              rst_n,
    input  logic              ftap_tdi,
    input  logic              capture_ir,
    input  logic              shift_ir,
    input  logic              update_ir,
    input  logic              tlr,
    input  stap_pkg::policy_t fdfx_secure_policy,
    input  logic              fdfx_policy_update,
    output logic              ir_so,
    output logic              sel_idcode,
    output logic              sel_tdr,
    output logic              sel_sec_tdr
);
    import stap_pkg::*;

    ir_t     ir_sr;
    ir_t     ir_q;
    policy_t policy_q;
    logic    sec_open_q;

    // ------------------------------------------------------------------
    // Shift stage
    // ------------------------------------------------------------------

    // Fixed pattern at capture, then LSB out and TDI into the MSB
    always_ff @(posedge ftap_tck) begin
        if (capture_ir) begin
            ir_sr <= IR_CAPTURE;
        end else if (shift_ir) begin
            ir_sr <= {ftap_tdi, ir_sr[IR_WIDTH-1:1]};
        end
    end

    assign ir_so = ir_sr[0];

    // ------------------------------------------------------------------
    // Policy latch and instruction shadow
    // ------------------------------------------------------------------

    // Policy is not touched by a TMS reset, only by rst_n
    always_ff @(posedge ftap_tck or negedge rst_n) begin
        if (!rst_n) begin
            policy_q <= '0;
        end else if (fdfx_policy_update) begin
            policy_q <= fdfx_secure_policy;
        end
    end

    // Unlock state is sampled together with the instruction, so a new
    // policy only matters from the next Update-IR on
    always_ff @(posedge ftap_tck or negedge rst_n) begin
        if (!rst_n) begin
            ir_q       <= IR_IDCODE;
            sec_open_q <= 1'b0;
        end else if (tlr) begin
            ir_q       <= IR_IDCODE;
            sec_open_q <= 1'b0;
        end else if (update_ir) begin
            ir_q       <= ir_sr;
            sec_open_q <= (policy_q == POLICY_UNLOCK);
        end
    end

    // ------------------------------------------------------------------
    // Register selects
    // ------------------------------------------------------------------

    always_comb begin
        sel_idcode  = 1'b0;
        sel_tdr     = 1'b0;
        sel_sec_tdr = 1'b0;
        case (ir_q)
            IR_IDCODE:  sel_idcode  = 1'b1;
            IR_TDR:     sel_tdr     = 1'b1;
            // Locked secure TDR falls back to bypass
            IR_SEC_TDR: sel_sec_tdr = sec_open_q;
            // BYPASS and unlisted codes select nothing
            default:    sel_idcode  = 1'b0;
        endcase
    end

    a_sel_onehot0 : assert property (@(posedge ftap_tck) disable iff (!rst_n)
        $onehot0({sel_idcode, sel_tdr, sel_sec_tdr}));

    // Secure TDR opens only through an Update-IR under the unlock policy
    a_sec_gate : assert property (@(posedge ftap_tck) disable iff (!rst_n)
        $rose(sel_sec_tdr) |-> $past(update_ir) && ($past(policy_q) == POLICY_UNLOCK));

endmodule

`default_nettype wire

// ==== source/stap_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module stap_fsm (
    input  logic ftap_tck,
    input  logic rst_n,
    input  logic ftap_tms,
    output logic capture_ir,
    output logic shift_ir,
    output logic update_ir,
    output logic capture_dr,
    output logic shift_dr,
    output logic update_dr,
    output logic tlr
);
    import stap_pkg::*;

    tap_state_t state_q;
    tap_state_t state_nxt;

    // ------------------------------------------------------------------
    // Next state, straight from the 1149.1 state diagram
    // ------------------------------------------------------------------

    always_comb begin
        state_nxt = TAP_TLR;
        case (state_q)
            TAP_TLR:      state_nxt = ftap_tms ? TAP_TLR      : TAP_RTI;
            TAP_RTI:      state_nxt = ftap_tms ? TAP_SEL_DR   : TAP_RTI;
            // DR column
            TAP_SEL_DR:   state_nxt = ftap_tms ? TAP_SEL_IR   : TAP_CAP_DR;
            TAP_CAP_DR:   state_nxt = ftap_tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR: state_nxt = ftap_tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR: state_nxt = ftap_tms ? TAP_UPD_DR   : TAP_PAUSE_DR;
            TAP_PAUSE_DR: state_nxt = ftap_tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR: state_nxt = ftap_tms ? TAP_UPD_DR   : TAP_SHIFT_DR;
            TAP_UPD_DR:   state_nxt = ftap_tms ? TAP_SEL_DR   : TAP_RTI;
            // IR column
            TAP_SEL_IR:   state_nxt = ftap_tms ? TAP_TLR      : TAP_CAP_IR;
            TAP_CAP_IR:   state_nxt = ftap_tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR: state_nxt = ftap_tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR: state_nxt = ftap_tms ? TAP_UPD_IR   : TAP_PAUSE_IR;
            TAP_PAUSE_IR: state_nxt = ftap_tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR: state_nxt = ftap_tms ? TAP_UPD_IR   : TAP_SHIFT_IR;
            TAP_UPD_IR:   state_nxt = ftap_tms ? TAP_SEL_DR   : TAP_RTI;
            default:      state_nxt = TAP_TLR;
        endcase
    end

    // State steps on every rising tck
    always_ff @(posedge ftap_tck or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= TAP_TLR;
        end else begin
            state_q <= state_nxt;
        end
    end

    // ------------------------------------------------------------------
    // Strobes decoded from the current state
    // ------------------------------------------------------------------

    // High for the whole cycle spent in the state
    // Registers act on the rising edge that ends it
    assign capture_ir = (state_q == TAP_CAP_IR);
    assign shift_ir   = (state_q == TAP_SHIFT_IR);
    assign update_ir  = (state_q == TAP_UPD_IR);
    assign capture_dr = (state_q == TAP_CAP_DR);
    assign shift_dr   = (state_q == TAP_SHIFT_DR);
    assign update_dr  = (state_q == TAP_UPD_DR);
    assign tlr        = (state_q == TAP_TLR);

    // Register strobes never overlap
    a_strobe_onehot0 : assert property (@(posedge ftap_tck) disable iff (!rst_n)
        $onehot0({capture_ir, shift_ir, update_ir, capture_dr, shift_dr, update_dr, tlr}));

    // Five TMS-high clocks reach Test-Logic-Reset from anywhere
    a_tms_reset : assert property (@(posedge ftap_tck) disable iff (!rst_n)
        (ftap_tms && $past(ftap_tms, 1) && $past(ftap_tms, 2) &&
         $past(ftap_tms, 3) && $past(ftap_tms, 4)) |=> tlr);

endmodule

`default_nettype wire

// ==== source/stap_pkg.sv ====
`default_nettype none

package stap_pkg;

    // ------------------------------------------------------------------
    // TAP controller states
    // ------------------------------------------------------------------

    // Encoding follows the 1149.1 state assignment
    typedef enum logic [3:0] {
        TAP_EXIT2_DR = 4'h0,
        TAP_EXIT1_DR = 4'h1,
        TAP_SHIFT_DR = 4'h2,
        TAP_PAUSE_DR = 4'h3,
        TAP_SEL_IR   = 4'h4,
        TAP_UPD_DR   = 4'h5,
        TAP_CAP_DR   = 4'h6,
        TAP_SEL_DR   = 4'h7,
        TAP_EXIT2_IR = 4'h8,
        TAP_EXIT1_IR = 4'h9,
        TAP_SHIFT_IR = 4'hA,
        TAP_PAUSE_IR = 4'hB,
        TAP_RTI      = 4'hC,
        TAP_UPD_IR   = 4'hD,
        TAP_CAP_IR   = 4'hE,
        TAP_TLR      = 4'hF
    } tap_state_t;

    // ------------------------------------------------------------------
    // Instruction register
    // ------------------------------------------------------------------

    localparam int IR_WIDTH = 4;
    typedef logic [IR_WIDTH-1:0] ir_t;

    // Opcodes; anything not listed behaves as BYPASS
    localparam ir_t IR_IDCODE  = 4'h1;
    localparam ir_t IR_TDR     = 4'h8;
    localparam ir_t IR_SEC_TDR = 4'h9;
    localparam ir_t IR_BYPASS  = 4'hF;

    // Two LSBs must be 01 at Capture-IR
    localparam ir_t IR_CAPTURE = 4'b0001;

    // ------------------------------------------------------------------
    // Data register payloads and security policy
    // ------------------------------------------------------------------

    localparam int IDCODE_WIDTH = 32;
    typedef logic [IDCODE_WIDTH-1:0] idcode_t;

    localparam int TDR_WIDTH = 16;
    typedef logic [TDR_WIDTH-1:0] tdr_t;

    localparam int POLICY_WIDTH = 4;
    typedef logic [POLICY_WIDTH-1:0] policy_t;

    // Only this policy value opens the secure TDR
    localparam policy_t POLICY_UNLOCK = 4'h2;

endpackage

`default_nettype wire
